// ==== rv32_core_pkg.sv ====
package rv32_core_pkg;

    localparam int XLEN      = 32;
    localparam int REG_COUNT = 32;
    localparam int MEM_WORDS = 256;  // 1 KiB, byte addresses 0 to 1023

    typedef logic [XLEN-1:0]              word_t;
    typedef logic [$clog2(REG_COUNT)-1:0] reg_addr_t;
    typedef logic [$clog2(MEM_WORDS)-1:0] mem_index_t;
    typedef logic [3:0]                   alu_op_t;

    localparam word_t EXIT_PC = 32'h0000_0100;

    // Major opcodes
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_LW      = 3'b010;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub, sra, srai

    // ALU_ADD is zero so an all-zero ctrl is a harmless no-op
    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_OR   = 4'd3;
    localparam alu_op_t ALU_XOR  = 4'd4;
    localparam alu_op_t ALU_SLL  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_SLT  = 4'd8;
    localparam alu_op_t ALU_SLTU = 4'd9;
    localparam alu_op_t BR_EQ    = 4'd10;
    localparam alu_op_t BR_NE    = 4'd11;
    localparam alu_op_t BR_LT    = 4'd12;
    localparam alu_op_t BR_GE    = 4'd13;
    localparam alu_op_t BR_LTU   = 4'd14;
    localparam alu_op_t BR_GEU   = 4'd15;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;    // Operand b from immediate
        logic    is_branch;
        logic    mem_wen;
        logic    rf_wen;
        logic    wb_mem;     // Writeback the loaded word
    } ctrl_t;

    typedef struct packed {
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        ctrl_t     ctrl;
    } dec_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  wen;
    } dmem_req_t;

endpackage

// ==== rv32_decoder.sv ====
`timescale 1ns/1ps

module rv32_decoder (
    input  rv32_core_pkg::word_t inst_i,
    output rv32_core_pkg::dec_t  dec_o
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    rv32_core_pkg::word_t imm_i;
    rv32_core_pkg::word_t imm_s;
    rv32_core_pkg::word_t imm_b;
    rv32_core_pkg::word_t imm;
    rv32_core_pkg::ctrl_t ctrl;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};

    always_comb begin
        case (opcode)
            rv32_core_pkg::OPC_LOAD,
            rv32_core_pkg::OPC_OP_IMM: imm = imm_i;
            rv32_core_pkg::OPC_STORE:  imm = imm_s;
            rv32_core_pkg::OPC_BRANCH: imm = imm_b;
            default:                   imm = '0;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            rv32_core_pkg::OPC_LOAD: begin
                if (funct3 == rv32_core_pkg::F3_LW) begin
                    ctrl.alu_op  = rv32_core_pkg::ALU_ADD;
                    ctrl.use_imm = 1'b1;
                    ctrl.rf_wen  = 1'b1;
                    ctrl.wb_mem  = 1'b1;
                end
            end
            rv32_core_pkg::OPC_STORE: begin
                if (funct3 == rv32_core_pkg::F3_SW) begin
                    ctrl.alu_op  = rv32_core_pkg::ALU_ADD;
                    ctrl.use_imm = 1'b1;
                    ctrl.mem_wen = 1'b1;
                end
            end
            rv32_core_pkg::OPC_OP: begin
                ctrl.rf_wen = 1'b1;
                case ({funct7, funct3})
                    {rv32_core_pkg::F7_BASE, rv32_core_pkg::F3_ADD_SUB}:
                        ctrl.alu_op = rv32_core_pkg::ALU_ADD;
                    {rv32_core_pkg::F7_ALT, rv32_core_pkg::F3_ADD_SUB}:
                        ctrl.alu_op = rv32_core_pkg::ALU_SUB;
                    {rv32_core_pkg::F7_BASE, rv32_core_pkg::F3_SLL}:
                        ctrl.alu_op = rv32_core_pkg::ALU_SLL;
                    {rv32_core_pkg::F7_BASE, rv32_core_pkg::F3_SLT}:
                        ctrl.alu_op = rv32_core_pkg::ALU_SLT;
                    {rv32_core_pkg::F7_BASE, rv32_core_pkg::F3_SLTU}:
                        ctrl.alu_op = rv32_core_pkg::ALU_SLTU;
                    {rv32_core_pkg::F7_BASE, rv32_core_pkg::F3_XOR}:
                        ctrl.alu_op = rv32_core_pkg::ALU_XOR;
                    {rv32_core_pkg::F7_BASE, rv32_core_pkg::F3_SRL_SRA}:
                        ctrl.alu_op = rv32_core_pkg::ALU_SRL;
                    {rv32_core_pkg::F7_ALT, rv32_core_pkg::F3_SRL_SRA}:
                        ctrl.alu_op = rv32_core_pkg::ALU_SRA;
                    {rv32_core_pkg::F7_BASE, rv32_core_pkg::F3_OR}:
                        ctrl.alu_op = rv32_core_pkg::ALU_OR;
                    {rv32_core_pkg::F7_BASE, rv32_core_pkg::F3_AND}:
                        ctrl.alu_op = rv32_core_pkg::ALU_AND;
                    default: ctrl.rf_wen = 1'b0;  // Unknown funct7
                endcase
            end
            rv32_core_pkg::OPC_OP_IMM: begin
                ctrl.use_imm = 1'b1;
                ctrl.rf_wen  = 1'b1;
                case (funct3)
                    rv32_core_pkg::F3_ADD_SUB: ctrl.alu_op = rv32_core_pkg::ALU_ADD;
                    rv32_core_pkg::F3_SLT:     ctrl.alu_op = rv32_core_pkg::ALU_SLT;
                    rv32_core_pkg::F3_SLTU:    ctrl.alu_op = rv32_core_pkg::ALU_SLTU;
                    rv32_core_pkg::F3_XOR:     ctrl.alu_op = rv32_core_pkg::ALU_XOR;
                    rv32_core_pkg::F3_OR:      ctrl.alu_op = rv32_core_pkg::ALU_OR;
                    rv32_core_pkg::F3_AND:     ctrl.alu_op = rv32_core_pkg::ALU_AND;
                    rv32_core_pkg::F3_SLL: begin
                        ctrl.alu_op = rv32_core_pkg::ALU_SLL;
                        ctrl.rf_wen = (funct7 == rv32_core_pkg::F7_BASE);
                    end
                    default: begin
                        // srli or srai, picked by funct7
                        if (funct7 == rv32_core_pkg::F7_ALT) begin
                            ctrl.alu_op = rv32_core_pkg::ALU_SRA;
                        end else begin
                            ctrl.alu_op = rv32_core_pkg::ALU_SRL;
                            ctrl.rf_wen = (funct7 == rv32_core_pkg::F7_BASE);
                        end
                    end
                endcase
            end
            rv32_core_pkg::OPC_BRANCH: begin
                ctrl.is_branch = 1'b1;
                case (funct3)
                    rv32_core_pkg::F3_BEQ:  ctrl.alu_op = rv32_core_pkg::BR_EQ;
                    rv32_core_pkg::F3_BNE:  ctrl.alu_op = rv32_core_pkg::BR_NE;
                    rv32_core_pkg::F3_BLT:  ctrl.alu_op = rv32_core_pkg::BR_LT;
                    rv32_core_pkg::F3_BGE:  ctrl.alu_op = rv32_core_pkg::BR_GE;
                    rv32_core_pkg::F3_BLTU: ctrl.alu_op = rv32_core_pkg::BR_LTU;
                    rv32_core_pkg::F3_BGEU: ctrl.alu_op = rv32_core_pkg::BR_GEU;
                    default:                ctrl.is_branch = 1'b0;
                endcase
            end
            default: ctrl = '0;
        endcase
    end

    assign dec_o.rs1  = inst_i[19:15];
    assign dec_o.rs2  = inst_i[24:20];
    assign dec_o.rd   = inst_i[11:7];
    assign dec_o.imm  = imm;
    assign dec_o.ctrl = ctrl;

endmodule

// ==== rv32_regfile.sv ====
`timescale 1ns/1ps

module rv32_regfile (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rv32_core_pkg::reg_addr_t rs1_i,
    input  rv32_core_pkg::reg_addr_t rs2_i,
    output rv32_core_pkg::word_t     rs1_data_o,
    output rv32_core_pkg::word_t     rs2_data_o,
    input  rv32_core_pkg::reg_addr_t rd_i,
    input  rv32_core_pkg::word_t     rd_data_i,
    input  logic                     wen_i
);

    rv32_core_pkg::word_t regs [rv32_core_pkg::REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rv32_core_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && (rd_i != '0)) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    // x0 reads as zero
    assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// ==== rv32_alu.sv ====
`timescale 1ns/1ps

module rv32_alu (
    input  rv32_core_pkg::alu_op_t op_i,
    input  rv32_core_pkg::word_t   a_i,
    input  rv32_core_pkg::word_t   b_i,
    output rv32_core_pkg::word_t   result_o,
    output logic                   cond_o
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];
    assign eq    = (a_i == b_i);
    assign lt_s  = ($signed(a_i) < $signed(b_i));
    assign lt_u  = (a_i < b_i);

    always_comb begin
        result_o = '0;
        cond_o   = 1'b0;
        case (op_i)
            rv32_core_pkg::ALU_ADD:  result_o = a_i + b_i;  // Also load/store address
            rv32_core_pkg::ALU_SUB:  result_o = a_i - b_i;
            rv32_core_pkg::ALU_AND:  result_o = a_i & b_i;
            rv32_core_pkg::ALU_OR:   result_o = a_i | b_i;
            rv32_core_pkg::ALU_XOR:  result_o = a_i ^ b_i;
            rv32_core_pkg::ALU_SLL:  result_o = a_i << shamt;
            rv32_core_pkg::ALU_SRL:  result_o = a_i >> shamt;
            rv32_core_pkg::ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            rv32_core_pkg::ALU_SLT:  result_o = {31'b0, lt_s};
            rv32_core_pkg::ALU_SLTU: result_o = {31'b0, lt_u};
            rv32_core_pkg::BR_EQ:    cond_o = eq;
            rv32_core_pkg::BR_NE:    cond_o = !eq;
            rv32_core_pkg::BR_LT:    cond_o = lt_s;
            rv32_core_pkg::BR_GE:    cond_o = !lt_s;
            rv32_core_pkg::BR_LTU:   cond_o = lt_u;
            rv32_core_pkg::BR_GEU:   cond_o = !lt_u;
            default:                 result_o = '0;
        endcase
    end

endmodule

// ==== rv32_core.sv ====
`timescale 1ns/1ps

module rv32_core (
    input  logic                     clk,
    input  logic                     rst_n,
    output rv32_core_pkg::word_t     imem_addr_o,
    input  rv32_core_pkg::word_t     imem_rdata_i,
    output rv32_core_pkg::dmem_req_t dmem_req_o,
    input  rv32_core_pkg::word_t     dmem_rdata_i,
    output logic                     halt_o
);

    rv32_core_pkg::word_t pc;
    rv32_core_pkg::word_t pc_plus4;
    rv32_core_pkg::word_t br_target;
    rv32_core_pkg::word_t pc_next;
    rv32_core_pkg::dec_t  dec;
    rv32_core_pkg::word_t rs1_data;
    rv32_core_pkg::word_t rs2_data;
    rv32_core_pkg::word_t op_b;
    rv32_core_pkg::word_t alu_result;
    rv32_core_pkg::word_t wb_data;
    logic                 alu_cond;
    logic                 commit;
    logic                 rf_wen;

    rv32_decoder i_decoder (
        .inst_i (imem_rdata_i),
        .dec_o  (dec)
    );

    rv32_regfile i_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_i      (dec.rs1),
        .rs2_i      (dec.rs2),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .rd_i       (dec.rd),
        .rd_data_i  (wb_data),
        .wen_i      (rf_wen)
    );

    rv32_alu i_alu (
        .op_i     (dec.ctrl.alu_op),
        .a_i      (rs1_data),
        .b_i      (op_b),
        .result_o (alu_result),
        .cond_o   (alu_cond)
    );

    assign halt_o = (pc == rv32_core_pkg::EXIT_PC);
    assign commit = rst_n && !halt_o;  // No state change in reset or halt

    assign op_b    = dec.ctrl.use_imm ? dec.imm : rs2_data;
    assign wb_data = dec.ctrl.wb_mem ? dmem_rdata_i : alu_result;
    assign rf_wen  = dec.ctrl.rf_wen && commit;

    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc + dec.imm;
    assign pc_next   = (dec.ctrl.is_branch && alu_cond) ? br_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!halt_o) begin
            pc <= pc_next;
        end
    end

    assign imem_addr_o = pc;

    // Data port, address from the ALU sum
    assign dmem_req_o.addr  = alu_result;
    assign dmem_req_o.wdata = rs2_data;
    assign dmem_req_o.wen   = dec.ctrl.mem_wen && commit;

endmodule

// ==== rv32_memory.sv ====
`timescale 1ns/1ps

module rv32_memory (
    input  logic                     clk,
    input  rv32_core_pkg::word_t     imem_addr_i,
    output rv32_core_pkg::word_t     imem_rdata_o,
    input  rv32_core_pkg::dmem_req_t dmem_req_i,
    output rv32_core_pkg::word_t     dmem_rdata_o
);

    localparam int IDX_MSB = $clog2(rv32_core_pkg::MEM_WORDS) + 1;

    rv32_core_pkg::word_t      mem [rv32_core_pkg::MEM_WORDS];
    rv32_core_pkg::mem_index_t imem_idx;
    rv32_core_pkg::mem_index_t dmem_idx;

    initial begin
        $readmemh("program.hex", mem);
    end

    // Word index, byte offset dropped
    assign imem_idx = imem_addr_i[IDX_MSB:2];
    assign dmem_idx = dmem_req_i.addr[IDX_MSB:2];

    assign imem_rdata_o = mem[imem_idx];
    assign dmem_rdata_o = mem[dmem_idx];

    always_ff @(posedge clk) begin
        if (dmem_req_i.wen) begin
            mem[dmem_idx] <= dmem_req_i.wdata;
        end
    end

endmodule

// ==== rv32_top.sv ====
`timescale 1ns/1ps

module rv32_top (
    input  logic                     clk,
    input  logic                     rst_n,
    output logic                     halt_o,
    output rv32_core_pkg::dmem_req_t dmem_req_o
);

    rv32_core_pkg::word_t     imem_addr;
    rv32_core_pkg::word_t     imem_rdata;
    rv32_core_pkg::word_t     dmem_rdata;
    rv32_core_pkg::dmem_req_t dmem_req;

    rv32_core i_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .dmem_req_o   (dmem_req),
        .dmem_rdata_i (dmem_rdata),
        .halt_o       (halt_o)
    );

    rv32_memory i_memory (
        .clk          (clk),
        .imem_addr_i  (imem_addr),
        .imem_rdata_o (imem_rdata),
        .dmem_req_i   (dmem_req),
        .dmem_rdata_o (dmem_rdata)
    );

    assign dmem_req_o = dmem_req;  // Store bus seen by the testbench

endmodule

// ==== tb_rv32_top.sv ====
`timescale 1ns/1ps

module tb_rv32_top;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int HALT_CYCLES  = 20;
    // Program runs about 70 instructions plus reset and halt watch
    localparam int MAX_CYCLES   = 2000;

    localparam rv32_core_pkg::word_t RESULT_BASE = 32'h0000_0200;
    localparam rv32_core_pkg::word_t SPILL_ADDR  = 32'h0000_02F8;  // 0x300 - 8
    localparam rv32_core_pkg::word_t POISON_ADDR = 32'h0000_02C0;

    // x1 and x2 as set by the first two instructions
    localparam rv32_core_pkg::word_t OP_A = -7;
    localparam rv32_core_pkg::word_t OP_B = 3;

    logic                     clk = 1'b0;
    logic                     rst_n = 1'b0;
    logic                     halt;
    rv32_core_pkg::dmem_req_t dmem_req;

    rv32_core_pkg::word_t exp_addr[$];
    rv32_core_pkg::word_t exp_data[$];
    int                   result_slot = 0;
    int                   store_idx = 0;
    int                   cycle_count = 0;

    rv32_top i_rv32_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .halt_o     (halt),
        .dmem_req_o (dmem_req)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_errors();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input rv32_core_pkg::word_t expected,
                                   input rv32_core_pkg::word_t actual);
        $display("[FAIL] %s expected 0x%08h, got 0x%08h", name, expected, actual);
        stop_with_errors();
    endtask

    task automatic abort_run(input string reason);
        $display("Error: %s", reason);
        stop_with_errors();
    endtask

    function automatic rv32_core_pkg::word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    task automatic add_store(input rv32_core_pkg::word_t addr, input rv32_core_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // Results fill consecutive words from RESULT_BASE
    task automatic next_result(input rv32_core_pkg::word_t data);
        add_store(RESULT_BASE + 32'(4 * result_slot), data);
        result_slot++;
    endtask

    task automatic build_expected();
        rv32_core_pkg::word_t a;
        rv32_core_pkg::word_t b;
        a = OP_A;
        b = OP_B;
        // Register forms write x3 = x1 op x2
        next_result(a + b);
        next_result(a - b);
        next_result(a & b);
        next_result(a | b);
        next_result(a ^ b);
        next_result(a << b[4:0]);
        next_result(a >> b[4:0]);
        next_result($signed(a) >>> b[4:0]);
        next_result(($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        next_result((a < b) ? 32'd1 : 32'd0);
        // Immediate forms
        next_result(a + sext12(12'd100));
        next_result(a & sext12(12'hFF0));
        next_result(b | sext12(12'hF00));  // ori reads x2
        next_result(a ^ sext12(12'h7FF));
        next_result(a << 4);
        next_result(a >> 28);
        next_result($signed(a) >>> 1);
        next_result(($signed(a) < $signed(sext12(12'hFFA))) ? 32'd1 : 32'd0);
        next_result((a < sext12(12'd5)) ? 32'd1 : 32'd0);
        next_result(32'd0);  // x0 after a write attempt
        // Spill at a negative offset followed by the reloaded copy
        add_store(SPILL_ADDR, a);
        next_result(a);
        // One marker from x2 per not-taken branch
        repeat (6) begin
            next_result(b);
        end
    endtask

    // Store monitor
    always @(posedge clk) begin
        if (dmem_req.wen) begin
            assert (rst_n) else abort_run("store issued while reset is asserted");
            assert (dmem_req.addr != POISON_ADDR)
                else abort_run("store to the poison address, a taken branch fell through");
            assert (store_idx < exp_addr.size())
                else abort_run("store after the last expected one");
            assert (dmem_req.addr == exp_addr[store_idx])
                else report_mismatch("dmem_req_o.addr", exp_addr[store_idx], dmem_req.addr);
            assert (dmem_req.wdata == exp_data[store_idx])
                else report_mismatch("dmem_req_o.wdata", exp_data[store_idx], dmem_req.wdata);
            store_idx++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        assert (cycle_count < MAX_CYCLES)
            else abort_run("timeout, the core never reached the exit address");
    end

    initial begin
        build_expected();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (halt === 1'b0) else report_mismatch("halt_o", 32'd0, 32'(halt));
        end
        rst_n = 1'b1;
        @(negedge clk);
        assert (halt === 1'b0) else report_mismatch("halt_o", 32'd0, 32'(halt));

        wait (halt === 1'b1);
        assert (store_idx == exp_addr.size())
            else abort_run("halt_o rose before all expected stores were seen");

        repeat (HALT_CYCLES) @(negedge clk);  // Nothing may move while halted
        assert (halt === 1'b1) else abort_run("halt_o fell after the exit address");

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== program.hex ====
// Instruction words in address order, one or two words per line
// Comment gives the byte address of the first word on the line, then the assembly
FF900093 00300113  // 000 addi x1,x0,-7 ; addi x2,x0,3
002081B3 20302023  // 008 add x3,x1,x2 ; sw x3,0x200(x0)
402081B3 20302223  // 010 sub ; sw 0x204
0020F1B3 20302423  // 018 and ; sw 0x208
0020E1B3 20302623  // 020 or ; sw 0x20c
0020C1B3 20302823  // 028 xor ; sw 0x210
002091B3 20302A23  // 030 sll ; sw 0x214
0020D1B3 20302C23  // 038 srl ; sw 0x218
4020D1B3 20302E23  // 040 sra ; sw 0x21c
0020A1B3 22302023  // 048 slt ; sw 0x220
0020B1B3 22302223  // 050 sltu ; sw 0x224
06408193 22302423  // 058 addi x3,x1,100 ; sw 0x228
FF00F193 22302623  // 060 andi x3,x1,-16 ; sw 0x22c
F0016193 22302823  // 068 ori x3,x2,-256 ; sw 0x230
7FF0C193 22302A23  // 070 xori x3,x1,0x7ff ; sw 0x234
00409193 22302C23  // 078 slli x3,x1,4 ; sw 0x238
01C0D193 22302E23  // 080 srli x3,x1,28 ; sw 0x23c
4010D193 24302023  // 088 srai x3,x1,1 ; sw 0x240
FFA0A193 24302223  // 090 slti x3,x1,-6 ; sw 0x244
0050B193 24302423  // 098 sltiu x3,x1,5 ; sw 0x248
04D00013 24002623  // 0a0 addi x0,x0,77 ; sw x0,0x24c(x0)
30000513 FE152C23  // 0a8 addi x10,x0,0x300 ; sw x1,-8(x10)
FF852283 24502823  // 0b0 lw x5,-8(x10) ; sw x5,0x250(x0)
00208463 24202A23  // 0b8 beq x1,x2,+8 not taken ; sw x2,0x254(x0)
00210463 2C102023  // 0c0 beq x2,x2,+8 taken ; sw x1,0x2c0(x0) poison
00109463 24202C23  // 0c8 bne x1,x1,+8 not taken ; marker 0x258
00209463 2C102023  // 0d0 bne x1,x2,+8 taken ; poison
00114463 24202E23  // 0d8 blt x2,x1,+8 not taken ; marker 0x25c
0020C463 2C102023  // 0e0 blt x1,x2,+8 taken ; poison
0020D463 26202023  // 0e8 bge x1,x2,+8 not taken ; marker 0x260
00115463 2C102023  // 0f0 bge x2,x1,+8 taken ; poison
00116663 2C102023  // 0f8 bltu x2,x1,+12 taken, hops the exit word ; poison
00000000           // 100 exit address, never executed
0020E463 26202223  // 104 bltu x1,x2,+8 not taken ; marker 0x264
00117463 26202423  // 10c bgeu x2,x1,+8 not taken ; marker 0x268
0020F463 2C102023  // 114 bgeu x1,x2,+8 taken ; poison
FE0002E3           // 11c beq x0,x0,-28 back to the exit address

// ==== rv32_core.f ====
rv32_core_pkg.sv
rv32_decoder.sv
rv32_regfile.sv
rv32_alu.sv
rv32_core.sv
rv32_memory.sv
rv32_top.sv
tb_rv32_top.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_rv32_top
FILELIST   := rv32_core.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
PASS_MSG   := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the simulation output holds the pass message
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
